/* cpu_wrapper.f */
design/cpu_wrapper_pkg.sv
design/store_aligner.sv
design/load_extractor.sv
design/response_timer.sv
design/axi_master.sv
design/cpu_wrapper.sv
dv/axi_slave_mem.sv
dv/cpu_wrapper_tb.sv

/* design/axi_master.sv */
`timescale 1ns/10ps

module axi_master
  import cpu_wrapper_pkg::*;
#(
  parameter logic [ID_WIDTH-1:0] MASTER_ID = '0
) (
  input  logic      clk,
  input  logic      arst_n_i,
  input  core_req_t core_req_i,
  output core_rsp_t core_rsp_o,
  output axi_req_t  axi_req_o,
  input  axi_rsp_t  axi_rsp_i
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    RESP,
    DONE
  } state_e;

  state_e state_q;
  state_e state_d;

  // access captured when leaving IDLE
  logic                  write_q;
  logic [F3_WIDTH-1:0]   func3_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] wdata_q;
  logic [STRB_WIDTH-1:0] wstrb_q;

  // write channel handshakes seen so far
  logic aw_done_q;
  logic w_done_q;

  // result shown to the core in DONE
  logic                  err_q;
  logic [DATA_WIDTH-1:0] rdata_q;

  logic [DATA_WIDTH-1:0] wdata_aligned;
  logic [STRB_WIDTH-1:0] wstrb_aligned;
  logic [DATA_WIDTH-1:0] load_data;
  logic                  timer_run;
  logic                  timer_expired;

  logic ar_hs;
  logic aw_hs;
  logic w_hs;
  logic r_hs;
  logic b_hs;
  logic aw_ok;
  logic w_ok;

  // lane placement straight from the core request
  store_aligner u_store_aligner (
    .func3_i   (core_req_i.func3),
    .addr_lo_i (core_req_i.addr[1:0]),
    .wdata_i   (core_req_i.wdata),
    .wdata_o   (wdata_aligned),
    .wstrb_o   (wstrb_aligned)
  );

  // load result from the live R data
  load_extractor u_load_extractor (
    .func3_i   (func3_q),
    .addr_lo_i (addr_q[1:0]),
    .rdata_i   (axi_rsp_i.rdata),
    .rdata_o   (load_data)
  );

  // runs only while waiting on the bus
  assign timer_run = (state_q == ADDR) || (state_q == RESP);

  response_timer u_response_timer (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .run_i     (timer_run),
    .expired_o (timer_expired)
  );

  // bus outputs, all decoded from registered state
  always_comb begin
    axi_req_o         = '0;
    axi_req_o.arvalid = (state_q == ADDR) && !write_q;
    axi_req_o.araddr  = addr_q;
    axi_req_o.arid    = MASTER_ID;
    axi_req_o.rready  = (state_q == RESP) && !write_q;
    // AW and W start together, each drops on its own handshake
    axi_req_o.awvalid = (state_q == ADDR) && write_q && !aw_done_q;
    axi_req_o.awaddr  = addr_q;
    axi_req_o.awid    = MASTER_ID;
    axi_req_o.wvalid  = (state_q == ADDR) && write_q && !w_done_q;
    axi_req_o.wdata   = wdata_q;
    axi_req_o.wstrb   = wstrb_q;
    axi_req_o.bready  = (state_q == RESP) && write_q;
  end

  assign ar_hs = axi_req_o.arvalid && axi_rsp_i.arready;
  assign aw_hs = axi_req_o.awvalid && axi_rsp_i.awready;
  assign w_hs  = axi_req_o.wvalid && axi_rsp_i.wready;
  assign r_hs  = axi_req_o.rready && axi_rsp_i.rvalid;
  assign b_hs  = axi_req_o.bready && axi_rsp_i.bvalid;

  // write address and data done, now or earlier
  assign aw_ok = aw_done_q || aw_hs;
  assign w_ok  = w_done_q || w_hs;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (core_req_i.req) state_d = ADDR;
      end
      ADDR: begin
        // a handshake in the expiry cycle still counts
        if (write_q ? (aw_ok && w_ok) : ar_hs) state_d = RESP;
        else if (timer_expired) state_d = DONE;
      end
      RESP: begin
        if (r_hs || b_hs || timer_expired) state_d = DONE;
      end
      DONE: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q   <= IDLE;
      write_q   <= 1'b0;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      err_q     <= 1'b0;
      rdata_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && core_req_i.req) begin
        // fresh transaction
        write_q   <= core_req_i.write;
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
        err_q     <= 1'b0;
        rdata_q   <= '0;
      end
      if (aw_hs) aw_done_q <= 1'b1;
      if (w_hs) w_done_q <= 1'b1;
      if (r_hs) begin
        rdata_q <= load_data;
        err_q   <= (axi_rsp_i.rresp != RESP_OKAY);
      end else if (b_hs) begin
        err_q <= (axi_rsp_i.bresp != RESP_OKAY);
      end else if (timer_run && state_d == DONE) begin
        // abandoned, no answer from the slave
        err_q   <= 1'b1;
        rdata_q <= '0;
      end
    end
  end

  // payload, only meaningful once a transaction has started
  always_ff @(posedge clk) begin
    if (state_q == IDLE && core_req_i.req) begin
      func3_q <= core_req_i.func3;
      addr_q  <= core_req_i.addr;
      wdata_q <= wdata_aligned;
      wstrb_q <= wstrb_aligned;
    end
  end

  // stall until DONE
  assign core_rsp_o.stall = core_req_i.req && (state_q != DONE);
  assign core_rsp_o.err   = err_q;
  assign core_rsp_o.rdata = rdata_q;

endmodule

/* design/cpu_wrapper.sv */
`timescale 1ns/10ps

module cpu_wrapper
  import cpu_wrapper_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n_i,
  // instruction fetch side of the core
  input  core_req_t inst_req_i,
  output core_rsp_t inst_rsp_o,
  // load and store side of the core
  input  core_req_t data_req_i,
  output core_rsp_t data_rsp_o,
  // bus port 0, instruction memory
  output axi_req_t  m0_axi_req_o,
  input  axi_rsp_t  m0_axi_rsp_i,
  // bus port 1, data memory
  output axi_req_t  m1_axi_req_o,
  input  axi_rsp_t  m1_axi_rsp_i
);

  // instruction master, ID 0
  // fetches are word reads, the core sets func3 and write itself
  axi_master #(
    .MASTER_ID (ID_WIDTH'(0))
  ) u_inst_master (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .core_req_i (inst_req_i),
    .core_rsp_o (inst_rsp_o),
    .axi_req_o  (m0_axi_req_o),
    .axi_rsp_i  (m0_axi_rsp_i)
  );

  // data master, ID 1
  // independent of the fetch port, no arbitration between them
  axi_master #(
    .MASTER_ID (ID_WIDTH'(1))
  ) u_data_master (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .core_req_i (data_req_i),
    .core_rsp_o (data_rsp_o),
    .axi_req_o  (m1_axi_req_o),
    .axi_rsp_i  (m1_axi_rsp_i)
  );

endmodule

/* design/cpu_wrapper_pkg.sv */
package cpu_wrapper_pkg;

  // bus geometry
  localparam int ADDR_WIDTH = 32;
  localparam int DATA_WIDTH = 32;
  localparam int ID_WIDTH   = 4;
  localparam int STRB_WIDTH = DATA_WIDTH / 8;
  localparam int RESP_WIDTH = 2;
  localparam int F3_WIDTH   = 3;

  // load func3 encodings
  localparam logic [F3_WIDTH-1:0] F3_LB  = 3'b000;
  localparam logic [F3_WIDTH-1:0] F3_LH  = 3'b001;
  localparam logic [F3_WIDTH-1:0] F3_LW  = 3'b010;
  localparam logic [F3_WIDTH-1:0] F3_LBU = 3'b100;
  localparam logic [F3_WIDTH-1:0] F3_LHU = 3'b101;
  // store func3 reuses the load width codes
  localparam logic [F3_WIDTH-1:0] F3_SB  = 3'b000;
  localparam logic [F3_WIDTH-1:0] F3_SH  = 3'b001;
  localparam logic [F3_WIDTH-1:0] F3_SW  = 3'b010;

  localparam logic [RESP_WIDTH-1:0] RESP_OKAY = 2'b00;

  // waiting cycles before a transaction is abandoned
  localparam int TIMEOUT_CYCLES = 64;
  localparam int TIMER_WIDTH    = $clog2(TIMEOUT_CYCLES);

  // one core access, held steady while stalled
  typedef struct packed {
    logic                  req;
    logic                  write;
    logic [F3_WIDTH-1:0]   func3;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } core_req_t;

  // answer back to the core
  typedef struct packed {
    logic                  stall;
    logic                  err;
    logic [DATA_WIDTH-1:0] rdata;
  } core_rsp_t;

  // master driven AXI-Lite signals
  typedef struct packed {
    logic                  arvalid;
    logic [ADDR_WIDTH-1:0] araddr;
    logic [ID_WIDTH-1:0]   arid;
    logic                  rready;
    logic                  awvalid;
    logic [ADDR_WIDTH-1:0] awaddr;
    logic [ID_WIDTH-1:0]   awid;
    logic                  wvalid;
    logic [DATA_WIDTH-1:0] wdata;
    logic [STRB_WIDTH-1:0] wstrb;
    logic                  bready;
  } axi_req_t;

  // slave driven AXI-Lite signals
  typedef struct packed {
    logic                  arready;
    logic                  rvalid;
    logic [DATA_WIDTH-1:0] rdata;
    logic [RESP_WIDTH-1:0] rresp;
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic [RESP_WIDTH-1:0] bresp;
  } axi_rsp_t;

  // bus word, whole or as byte lanes
  typedef union packed {
    logic [DATA_WIDTH-1:0]       word;
    logic [STRB_WIDTH-1:0][7:0]  bytes;
  } bus_word_u;

endpackage

/* design/load_extractor.sv */
`timescale 1ns/10ps

module load_extractor
  import cpu_wrapper_pkg::*;
(
  input  logic [F3_WIDTH-1:0]   func3_i,
  input  logic [1:0]            addr_lo_i,
  input  logic [DATA_WIDTH-1:0] rdata_i,
  output logic [DATA_WIDTH-1:0] rdata_o
);

  // read word seen as byte lanes
  bus_word_u   word_w;
  logic [7:0]  byte_w;
  logic [15:0] half_w;

  assign word_w = rdata_i;

  // addressed byte
  assign byte_w = word_w.bytes[addr_lo_i];

  // addressed halfword, bit 0 ignored (aligned only)
  assign half_w = {word_w.bytes[{addr_lo_i[1], 1'b1}], word_w.bytes[{addr_lo_i[1], 1'b0}]};

  always_comb begin
    case (func3_i)
      // signed byte
      F3_LB:   rdata_o = {{(DATA_WIDTH-8){byte_w[7]}}, byte_w};
      // unsigned byte
      F3_LBU:  rdata_o = {{(DATA_WIDTH-8){1'b0}}, byte_w};
      // signed half
      F3_LH:   rdata_o = {{(DATA_WIDTH-16){half_w[15]}}, half_w};
      // unsigned half
      F3_LHU:  rdata_o = {{(DATA_WIDTH-16){1'b0}}, half_w};
      F3_LW:   rdata_o = word_w.word;
      // anything else passes the word through
      default: rdata_o = word_w.word;
    endcase
  end

endmodule

/* design/response_timer.sv */
`timescale 1ns/10ps

module response_timer
  import cpu_wrapper_pkg::*;
(
  input  logic clk,
  input  logic arst_n_i,
  input  logic run_i,
  output logic expired_o
);

  // cycles spent waiting on the current transaction
  logic [TIMER_WIDTH-1:0] count_q;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else if (!run_i) begin
      // idle between transactions
      count_q <= '0;
    end else if (!expired_o) begin
      count_q <= count_q + 1'b1;
    end
  end

  // hold at the limit, master leaves the wait states next cycle
  assign expired_o = run_i && (count_q == TIMER_WIDTH'(TIMEOUT_CYCLES - 1));

endmodule

/* design/store_aligner.sv */
`timescale 1ns/10ps

module store_aligner
  import cpu_wrapper_pkg::*;
(
  input  logic [F3_WIDTH-1:0]   func3_i,
  input  logic [1:0]            addr_lo_i,
  input  logic [DATA_WIDTH-1:0] wdata_i,
  output logic [DATA_WIDTH-1:0] wdata_o,
  output logic [STRB_WIDTH-1:0] wstrb_o
);

  // lane view of the outgoing word
  bus_word_u word_w;

  always_comb begin
    word_w  = '0;
    wstrb_o = '0;
    case (func3_i)
      F3_SB: begin
        // same byte in every lane, strobe picks the one that lands
        word_w.bytes = {STRB_WIDTH{wdata_i[7:0]}};
        wstrb_o      = STRB_WIDTH'(1) << addr_lo_i;
      end
      F3_SH: begin
        // halfword in both halves
        word_w.word = {2{wdata_i[15:0]}};
        // upper or lower half by addr bit 1
        wstrb_o     = addr_lo_i[1] ? 4'b1100 : 4'b0011;
      end
      F3_SW: begin
        word_w.word = wdata_i;
        wstrb_o     = '1;
      end
      default: begin
        // unknown width treated as a full word
        word_w.word = wdata_i;
        wstrb_o     = '1;
      end
    endcase
  end

  assign wdata_o = word_w.word;

endmodule

/* dv/axi_slave_mem.sv */
`timescale 1ns/10ps

module axi_slave_mem
  import cpu_wrapper_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n_i,
  input  axi_req_t axi_req_i,
  output axi_rsp_t axi_rsp_o
);

  // 256 words, indexed by addr[9:2]
  logic [DATA_WIDTH-1:0] mem [256];
  integer                seed;

  // per channel wait counters
  int ar_wait;
  int r_wait;
  int aw_wait;
  int w_wait;
  int b_wait;

  logic                  r_pend;
  logic                  aw_got;
  logic                  w_got;
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [STRB_WIDTH-1:0] wr_strb;

  // top half of the map never answers
  function automatic logic is_silent(input logic [ADDR_WIDTH-1:0] addr);
    return addr >= 32'h8000_0000;
  endfunction

  // 0x4000_0000 up to the silent region answers with SLVERR
  function automatic logic is_error_region(input logic [ADDR_WIDTH-1:0] addr);
    return (addr >= 32'h4000_0000) && (addr < 32'h8000_0000);
  endfunction

  // 0 to 5 cycles
  function automatic int next_delay();
    return {$random(seed)} % 6;
  endfunction

  initial begin
    seed = 32;
    // fill depends on every index bit
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hA000_0000 + i * 32'h0101_0101;
    end
  end

  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      axi_rsp_o <= '0;
      r_pend    <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      ar_wait   <= 0;
      r_wait    <= 0;
      aw_wait   <= 0;
      w_wait    <= 0;
      b_wait    <= 0;
    end else begin
      // read address
      if (axi_req_i.arvalid && axi_rsp_o.arready) begin
        axi_rsp_o.arready <= 1'b0;
        rd_addr           <= axi_req_i.araddr;
        r_pend            <= 1'b1;
        r_wait            <= next_delay();
        ar_wait           <= next_delay();
      end else if (axi_req_i.arvalid && !r_pend && !is_silent(axi_req_i.araddr)) begin
        if (ar_wait == 0) axi_rsp_o.arready <= 1'b1;
        else ar_wait <= ar_wait - 1;
      end
      // read data
      if (axi_rsp_o.rvalid && axi_req_i.rready) begin
        axi_rsp_o.rvalid <= 1'b0;
        r_pend           <= 1'b0;
      end else if (r_pend && !axi_rsp_o.rvalid) begin
        if (r_wait == 0) begin
          axi_rsp_o.rvalid <= 1'b1;
          // SLVERR carries no data
          axi_rsp_o.rdata  <= is_error_region(rd_addr) ? '0 : mem[rd_addr[9:2]];
          axi_rsp_o.rresp  <= is_error_region(rd_addr) ? 2'b10 : RESP_OKAY;
        end else begin
          r_wait <= r_wait - 1;
        end
      end
      // write address
      if (axi_req_i.awvalid && axi_rsp_o.awready) begin
        axi_rsp_o.awready <= 1'b0;
        wr_addr           <= axi_req_i.awaddr;
        aw_got            <= 1'b1;
        aw_wait           <= next_delay();
      end else if (axi_req_i.awvalid && !aw_got && !is_silent(axi_req_i.awaddr)) begin
        if (aw_wait == 0) axi_rsp_o.awready <= 1'b1;
        else aw_wait <= aw_wait - 1;
      end
      // write data, held back while the address is silent
      if (axi_req_i.wvalid && axi_rsp_o.wready) begin
        axi_rsp_o.wready <= 1'b0;
        wr_data          <= axi_req_i.wdata;
        wr_strb          <= axi_req_i.wstrb;
        w_got            <= 1'b1;
        w_wait           <= next_delay();
      end else if (axi_req_i.wvalid && !w_got &&
                   (aw_got || (axi_req_i.awvalid && !is_silent(axi_req_i.awaddr)))) begin
        if (w_wait == 0) axi_rsp_o.wready <= 1'b1;
        else w_wait <= w_wait - 1;
      end
      // write response once both halves are in
      if (axi_rsp_o.bvalid && axi_req_i.bready) begin
        axi_rsp_o.bvalid <= 1'b0;
        aw_got           <= 1'b0;
        w_got            <= 1'b0;
        b_wait           <= next_delay();
      end else if (aw_got && w_got && !axi_rsp_o.bvalid) begin
        if (b_wait == 0) begin
          axi_rsp_o.bvalid <= 1'b1;
          axi_rsp_o.bresp  <= is_error_region(wr_addr) ? 2'b10 : RESP_OKAY;
          // only strobed lanes change, error region left alone
          for (int b = 0; b < STRB_WIDTH; b++) begin
            if (wr_strb[b] && !is_error_region(wr_addr)) begin
              mem[wr_addr[9:2]][8*b +: 8] <= wr_data[8*b +: 8];
            end
          end
        end else begin
          b_wait <= b_wait - 1;
        end
      end
    end
  end

endmodule

/* dv/cpu_wrapper_tb.sv */
`timescale 1ns/10ps

module cpu_wrapper_tb
  import cpu_wrapper_pkg::*;
();

  // one table row, port 0 is fetch and port 1 is data
  typedef struct packed {
    logic                  port;
    logic                  write;
    logic [F3_WIDTH-1:0]   func3;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
    logic [DATA_WIDTH-1:0] exp_rdata;
    logic                  exp_err;
  } entry_t;

  logic      clk = 1'b0;
  logic      arst_n;
  core_req_t inst_req;
  core_req_t data_req;
  core_rsp_t inst_rsp;
  core_rsp_t data_rsp;
  axi_req_t  m0_req;
  axi_req_t  m1_req;
  axi_rsp_t  m0_rsp;
  axi_rsp_t  m1_rsp;

  entry_t stim[$];
  int     error_count;
  int     cycle_count = 0;
  int     timeout_limit;

  always #5 clk = ~clk;

  cpu_wrapper u_cpu_wrapper (
    .clk          (clk),
    .arst_n_i     (arst_n),
    .inst_req_i   (inst_req),
    .inst_rsp_o   (inst_rsp),
    .data_req_i   (data_req),
    .data_rsp_o   (data_rsp),
    .m0_axi_req_o (m0_req),
    .m0_axi_rsp_i (m0_rsp),
    .m1_axi_req_o (m1_req),
    .m1_axi_rsp_i (m1_rsp)
  );

  // separate memories, same fill
  axi_slave_mem u_inst_mem (
    .clk       (clk),
    .arst_n_i  (arst_n),
    .axi_req_i (m0_req),
    .axi_rsp_o (m0_rsp)
  );

  axi_slave_mem u_data_mem (
    .clk       (clk),
    .arst_n_i  (arst_n),
    .axi_req_i (m1_req),
    .axi_rsp_o (m1_rsp)
  );

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Error: time %0t %s got 0x%08h expected 0x%08h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // IDs on every address beat, fetch master 0 and data master 1
  always @(negedge clk) begin
    if (arst_n && m0_req.arvalid) begin
      compare_value("m0 arid", m0_req.arid, 0);
    end
    if (arst_n && m0_req.awvalid) begin
      compare_value("m0 awid", m0_req.awid, 0);
    end
    if (arst_n && m1_req.arvalid) begin
      compare_value("m1 arid", m1_req.arid, 1);
    end
    if (arst_n && m1_req.awvalid) begin
      compare_value("m1 awid", m1_req.awid, 1);
    end
  end

  task automatic add_entry(input logic port, input logic write,
                           input logic [F3_WIDTH-1:0] func3,
                           input logic [ADDR_WIDTH-1:0] addr,
                           input logic [DATA_WIDTH-1:0] wdata,
                           input logic [DATA_WIDTH-1:0] exp_rdata, input logic exp_err);
    stim.push_back({port, write, func3, addr, wdata, exp_rdata, exp_err});
  endtask

  // memory fill is 0xA000_0000 + index * 0x0101_0101
  task automatic build_table();
    // word write then read back
    add_entry(1'b1, 1'b1, F3_SW, 32'h0000_0010, 32'h1234_5678, 32'h0000_0000, 1'b0);
    add_entry(1'b1, 1'b0, F3_LW, 32'h0000_0010, 32'h0, 32'h1234_5678, 1'b0);
    // byte lanes one at a time
    add_entry(1'b1, 1'b1, F3_SW, 32'h0000_0020, 32'h1122_3344, 32'h0000_0000, 1'b0);
    add_entry(1'b1, 1'b1, F3_SB, 32'h0000_0020, 32'hFFFF_FF81, 32'h0000_0000, 1'b0);
    // untouched lanes keep the old word
    add_entry(1'b1, 1'b0, F3_LW, 32'h0000_0020, 32'h0, 32'h1122_3381, 1'b0);
    add_entry(1'b1, 1'b1, F3_SB, 32'h0000_0021, 32'h0000_0092, 32'h0000_0000, 1'b0);
    add_entry(1'b1, 1'b1, F3_SB, 32'h0000_0022, 32'h0000_00A3, 32'h0000_0000, 1'b0);
    add_entry(1'b1, 1'b1, F3_SB, 32'h0000_0023, 32'h0000_00B4, 32'h0000_0000, 1'b0);
    add_entry(1'b1, 1'b0, F3_LW, 32'h0000_0020, 32'h0, 32'hB4A3_9281, 1'b0);
    // halfwords over the fill word 0xA909_0909
    add_entry(1'b1, 1'b1, F3_SH, 32'h0000_0024, 32'h0000_C5D6, 32'h0000_0000, 1'b0);
    add_entry(1'b1, 1'b0, F3_LW, 32'h0000_0024, 32'h0, 32'hA909_C5D6, 1'b0);
    add_entry(1'b1, 1'b1, F3_SH, 32'h0000_0026, 32'h1234_E7F8, 32'h0000_0000, 1'b0);
    add_entry(1'b1, 1'b0, F3_LW, 32'h0000_0024, 32'h0, 32'hE7F8_C5D6, 1'b0);
    // narrow loads, every byte has its top bit set
    add_entry(1'b1, 1'b0, F3_LB, 32'h0000_0020, 32'h0, 32'hFFFF_FF81, 1'b0);
    add_entry(1'b1, 1'b0, F3_LBU, 32'h0000_0021, 32'h0, 32'h0000_0092, 1'b0);
    add_entry(1'b1, 1'b0, F3_LB, 32'h0000_0022, 32'h0, 32'hFFFF_FFA3, 1'b0);
    add_entry(1'b1, 1'b0, F3_LBU, 32'h0000_0023, 32'h0, 32'h0000_00B4, 1'b0);
    add_entry(1'b1, 1'b0, F3_LH, 32'h0000_0020, 32'h0, 32'hFFFF_9281, 1'b0);
    add_entry(1'b1, 1'b0, F3_LHU, 32'h0000_0022, 32'h0, 32'h0000_B4A3, 1'b0);
    add_entry(1'b1, 1'b0, F3_LH, 32'h0000_0026, 32'h0, 32'hFFFF_E7F8, 1'b0);
    add_entry(1'b1, 1'b0, F3_LHU, 32'h0000_0024, 32'h0, 32'h0000_C5D6, 1'b0);
    // SLVERR region, write aliases word 0x20 and must not land
    add_entry(1'b1, 1'b0, F3_LW, 32'h4000_0010, 32'h0, 32'h0000_0000, 1'b1);
    add_entry(1'b1, 1'b1, F3_SW, 32'h4000_0020, 32'hFFFF_FFFF, 32'h0000_0000, 1'b1);
    add_entry(1'b1, 1'b0, F3_LW, 32'h0000_0020, 32'h0, 32'hB4A3_9281, 1'b0);
    // silent region, only the timer ends these
    add_entry(1'b1, 1'b0, F3_LW, 32'h8000_0000, 32'h0, 32'h0000_0000, 1'b1);
    add_entry(1'b1, 1'b1, F3_SW, 32'h9000_0004, 32'hDEAD_BEEF, 32'h0000_0000, 1'b1);
    add_entry(1'b1, 1'b0, F3_LW, 32'h0000_0004, 32'h0, 32'hA101_0101, 1'b0);
    // fetch port, runs beside the data traffic
    add_entry(1'b0, 1'b0, F3_LW, 32'h0000_0000, 32'h0, 32'hA000_0000, 1'b0);
    add_entry(1'b0, 1'b0, F3_LW, 32'h0000_0004, 32'h0, 32'hA101_0101, 1'b0);
    add_entry(1'b0, 1'b0, F3_LW, 32'h0000_0008, 32'h0, 32'hA202_0202, 1'b0);
    add_entry(1'b0, 1'b0, F3_LW, 32'h0000_000C, 32'h0, 32'hA303_0303, 1'b0);
    add_entry(1'b0, 1'b0, F3_LW, 32'h0000_0100, 32'h0, 32'hE040_4040, 1'b0);
    add_entry(1'b0, 1'b0, F3_LW, 32'h0000_0200, 32'h0, 32'h2080_8080, 1'b0);
    add_entry(1'b0, 1'b0, F3_LW, 32'h0000_03FC, 32'h0, 32'h9FFF_FFFF, 1'b0);
    add_entry(1'b0, 1'b0, F3_LH, 32'h0000_000A, 32'h0, 32'hFFFF_A202, 1'b0);
    add_entry(1'b0, 1'b0, F3_LBU, 32'h0000_000D, 32'h0, 32'h0000_0003, 1'b0);
    // fetch port write and read back, same master logic as data
    add_entry(1'b0, 1'b1, F3_SW, 32'h0000_0300, 32'h5A5A_A5A5, 32'h0000_0000, 1'b0);
    add_entry(1'b0, 1'b0, F3_LW, 32'h0000_0300, 32'h0, 32'h5A5A_A5A5, 1'b0);
  endtask

  task automatic set_req(input logic port, input core_req_t req);
    if (port) data_req = req;
    else inst_req = req;
  endtask

  function automatic core_rsp_t get_rsp(input logic port);
    return port ? data_rsp : inst_rsp;
  endfunction

  // nothing on the buses and no stall before the first request
  task automatic check_idle_bus();
    compare_value("m0 valid and ready after reset",
                  {m0_req.arvalid, m0_req.awvalid, m0_req.wvalid, m0_req.rready, m0_req.bready}, 0);
    compare_value("m1 valid and ready after reset",
                  {m1_req.arvalid, m1_req.awvalid, m1_req.wvalid, m1_req.rready, m1_req.bready}, 0);
    compare_value("stall after reset", {inst_rsp.stall, data_rsp.stall}, 0);
    compare_value("err after reset", {inst_rsp.err, data_rsp.err}, 0);
    compare_value("inst rdata after reset", inst_rsp.rdata, 0);
    compare_value("data rdata after reset", data_rsp.rdata, 0);
  endtask

  // plays the core on one port, table rows for the other port are skipped
  task automatic run_port(input logic port);
    entry_t    e;
    core_req_t req;
    core_rsp_t rsp;
    int        waited;
    for (int i = 0; i < stim.size(); i++) begin
      e = stim[i];
      if (e.port == port) begin
        @(posedge clk);
        #1;
        req = {1'b1, e.write, e.func3, e.addr, e.wdata};
        set_req(port, req);
        waited = 0;
        // outputs settle mid cycle
        @(negedge clk);
        rsp = get_rsp(port);
        while (rsp.stall) begin
          waited++;
          @(negedge clk);
          rsp = get_rsp(port);
        end
        // DONE cycle
        compare_value($sformatf("entry %0d rdata", i), rsp.rdata, e.exp_rdata);
        compare_value($sformatf("entry %0d err", i), rsp.err, e.exp_err);
        // request, address and response phases at least
        compare_value($sformatf("entry %0d minimum latency", i), waited >= 3, 1);
        if (e.addr >= 32'h8000_0000) begin
          compare_value($sformatf("entry %0d stalled until timeout", i),
                        waited >= TIMEOUT_CYCLES, 1);
        end
      end
    end
    @(posedge clk);
    #1;
    set_req(port, '0);
  endtask

  initial begin
    inst_req    = '0;
    data_req    = '0;
    arst_n      = 1'b0;
    error_count = 0;
    build_table();
    timeout_limit = stim.size() * (TIMEOUT_CYCLES + 20);
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(negedge clk);
    check_idle_bus();
    // both ports at once
    fork
      run_port(1'b0);
      run_port(1'b1);
    join
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
